// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert -j 0
TOP       = tb_vic
FILELIST  = sim.f

OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
PASS_MSG  = sim passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only when the pass line shows up in the output
run: compile
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: common/vic_consts.svh
`ifndef VIC_CONSTS_SVH
`define VIC_CONSTS_SVH

// chip type codes, as driven on chip_i
`define CHIP6567R8         2'd0
`define CHIP6567R56A       2'd1
`define CHIP6569           2'd2

// last raster x per chip (520, 512 and 504 dots per line)
`define RASTER_X_MAX_R8    10'd519
`define RASTER_X_MAX_R56A  10'd511
`define RASTER_X_MAX_6569  10'd503

// last raster line per chip (263, 262 and 312 lines)
`define RASTER_Y_MAX_R8    9'd262
`define RASTER_Y_MAX_R56A  9'd261
`define RASTER_Y_MAX_6569  9'd311

// clk_dot4x ticks in one phi half-phase
`define TICKS_PER_HALF     16

// dram strobe shapes, msb goes out first after the reload
`define RAS_PROFILE        16'b1100_0000_0011_1111
`define CAS_PROFILE        16'b1111_0000_0001_1111

// lines that can become badlines
`define BADLINE_FIRST      9'd48
`define BADLINE_LAST       9'd247
// cycles with ba low on a badline (c-access plus 3 cycles of warning)
`define BA_CHARS_FIRST     7'd12
`define BA_CHARS_LAST      7'd54

// register offsets
`define REG_CTRL1          6'h11
`define REG_RASTER         6'h12
`define REG_IRQ_STATUS     6'h19
`define REG_IRQ_ENABLE     6'h1a
`define REG_RESERVED_VALUE 8'hff

`endif

// File: common/vic_pkg.sv
`include "vic_consts.svh"

package vic_pkg;

   // which video chip the timing follows
   typedef enum logic [1:0] {
      CHIP_R8   = `CHIP6567R8,
      CHIP_R56A = `CHIP6567R56A,
      CHIP_6569 = `CHIP6569
   } chip_t;

   // clock strobes, all valid for one clk_dot4x tick
   typedef struct packed {
      logic phi;
      logic dot_rise;
      logic phase_first;
      logic phase_last;
      logic phase_third;
   } phase_t;

   typedef struct packed {
      logic [9:0] raster_x;
      logic [8:0] raster_line;
   } raster_t;

   // cpu side bus, sampled once per phi cycle
   typedef struct packed {
      logic       ce_n;
      logic       rw;
      logic [5:0] adr;
      logic [7:0] wdata;
   } cpu_bus_t;

   // control bits the arbiter needs
   typedef struct packed {
      logic       den;
      logic [2:0] yscroll;
      logic [8:0] raster_cmp;
   } ctrl_t;

endpackage

// File: raster/bus_arbiter.sv
`timescale 1ns/1ps
`include "vic_consts.svh"

module bus_arbiter
   import vic_pkg::*;
(
   input  logic    clk_dot4x,
   input  logic    rst,
   input  phase_t  phase_i,
   input  raster_t raster_i,
   input  ctrl_t   ctrl_i,
   output logic    ba_o,
   output logic    aec_o
);

   logic [6:0] cycle_num;
   logic       allow_q;
   logic       badline;
   logic       ba1_q;
   logic       ba2_q;
   logic       ba3_q;
   logic       phi_next;
   logic       aec_q;

   // one cycle is 8 dots
   assign cycle_num = raster_i.raster_x[9:3];

   // den only counts on line 48, flag drops once past the window
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         allow_q <= 1'b0;
      end else if (phase_i.phase_last) begin
         if (raster_i.raster_line == `BADLINE_FIRST && ctrl_i.den) begin
            allow_q <= 1'b1;
         end
         if (raster_i.raster_line > `BADLINE_LAST) begin
            allow_q <= 1'b0;
         end
      end
   end

   assign badline = allow_q &&
                    raster_i.raster_line >= `BADLINE_FIRST &&
                    raster_i.raster_line <= `BADLINE_LAST &&
                    raster_i.raster_line[2:0] == ctrl_i.yscroll;

   // ba low over the c-access window of a badline
   assign ba_o = !(badline && cycle_num >= `BA_CHARS_FIRST &&
                   cycle_num <= `BA_CHARS_LAST);

   // cascade at the end of each phi high phase,
   // ba3 lets the cpu keep 3 more high phases after ba falls
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         ba1_q <= 1'b1;
         ba2_q <= 1'b1;
         ba3_q <= 1'b1;
      end else if (phase_i.phi && phase_i.phase_last) begin
         ba1_q <= ba_o;
         ba2_q <= ba1_q | ba_o;
         ba3_q <= ba2_q | ba_o;
      end
   end

   // phi level of the next tick
   assign phi_next = phase_i.phi ^ phase_i.phase_last;

   // registered one tick early so aec lines up with phi
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         aec_q <= 1'b0;
      end else begin
         aec_q <= phi_next & (ba_o | ba3_q);
      end
   end

   assign aec_o = aec_q;

   // vic owns the bus in every phi low half
   a_aec_low_in_phi_low: assert property (@(posedge clk_dot4x) disable iff (rst)
      !phase_i.phi |-> !aec_o);

endmodule

// File: raster/raster_counter.sv
`timescale 1ns/1ps
`include "vic_consts.svh"

module raster_counter
   import vic_pkg::*;
(
   input  logic    clk_dot4x,
   input  logic    rst,
   input  chip_t   chip_i,
   input  phase_t  phase_i,
   output raster_t raster_o
);

   logic [9:0] x_max;
   logic [8:0] y_max;
   logic [9:0] x_q;
   logic [8:0] line_q;

   // per chip line length and frame height
   always_comb begin
      case (chip_i)
         CHIP_R8: begin
            x_max = `RASTER_X_MAX_R8;
            y_max = `RASTER_Y_MAX_R8;
         end
         CHIP_R56A: begin
            x_max = `RASTER_X_MAX_R56A;
            y_max = `RASTER_Y_MAX_R56A;
         end
         // pal, also taken for the unused code
         default: begin
            x_max = `RASTER_X_MAX_6569;
            y_max = `RASTER_Y_MAX_6569;
         end
      endcase
   end

   // one x step per dot, line steps when x wraps
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         x_q    <= '0;
         line_q <= '0;
      end else if (phase_i.dot_rise) begin
         if (x_q == x_max) begin
            x_q <= '0;
            if (line_q == y_max) begin
               line_q <= '0;
            end else begin
               line_q <= line_q + 9'd1;
            end
         end else begin
            x_q <= x_q + 10'd1;
         end
      end
   end

   assign raster_o = '{raster_x: x_q, raster_line: line_q};

   // trips when chip_i moves to a shorter line without a reset
   a_x_in_range: assert property (@(posedge clk_dot4x) disable iff (rst)
      x_q <= x_max);

endmodule

// File: regs/vic_registers.sv
`timescale 1ns/1ps
`include "vic_consts.svh"

module vic_registers
   import vic_pkg::*;
(
   input  logic       clk_dot4x,
   input  logic       rst,
   input  phase_t     phase_i,
   input  raster_t    raster_i,
   input  cpu_bus_t   bus_i,
   output ctrl_t      ctrl_o,
   output logic [7:0] dbo_o,
   output logic       irq_o
);

   ctrl_t ctrl_q;
   logic  irq_en_q;
   // raster irq latch and its once-per-line guard
   logic  irst_q;
   logic  irst_done_q;
   logic  wr_en;

   // cpu write lands on the last tick of phi high
   assign wr_en = phase_i.phi && phase_i.phase_last && !bus_i.ce_n && !bus_i.rw;

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         ctrl_q      <= '0;
         irq_en_q    <= 1'b0;
         irst_q      <= 1'b0;
         irst_done_q <= 1'b0;
      end else begin
         // compare once per half-phase start, latch only the first hit
         if (phase_i.phase_first) begin
            if (raster_i.raster_line == ctrl_q.raster_cmp) begin
               if (!irst_done_q) begin
                  irst_done_q <= 1'b1;
                  irst_q      <= 1'b1;
               end
            end else begin
               irst_done_q <= 1'b0;
            end
         end
         if (wr_en) begin
            case (bus_i.adr)
               `REG_CTRL1: begin
                  ctrl_q.raster_cmp[8] <= bus_i.wdata[7];
                  ctrl_q.den           <= bus_i.wdata[4];
                  ctrl_q.yscroll       <= bus_i.wdata[2:0];
               end
               `REG_RASTER: ctrl_q.raster_cmp[7:0] <= bus_i.wdata;
               // write one to acknowledge
               `REG_IRQ_STATUS: begin
                  if (bus_i.wdata[0]) begin
                     irst_q <= 1'b0;
                  end
               end
               `REG_IRQ_ENABLE: irq_en_q <= bus_i.wdata[0];
               default: ;
            endcase
         end
      end
   end

   assign irq_o  = irst_q & irq_en_q;
   assign ctrl_o = ctrl_q;

   // read mux, raster reads show the live line and not the compare
   always_comb begin
      case (bus_i.adr)
         `REG_CTRL1: dbo_o = {raster_i.raster_line[8], 2'b00, ctrl_q.den,
                              1'b0, ctrl_q.yscroll};
         `REG_RASTER:     dbo_o = raster_i.raster_line[7:0];
         `REG_IRQ_STATUS: dbo_o = {irq_o, 6'b000000, irst_q};
         `REG_IRQ_ENABLE: dbo_o = {7'b0000000, irq_en_q};
         default:         dbo_o = `REG_RESERVED_VALUE;
      endcase
   end

   // register state only moves on a phi high sampling tick
   a_wr_in_phi_high: assert property (@(posedge clk_dot4x) disable iff (rst)
      !$stable({ctrl_q, irq_en_q}) |-> $past(phase_i.phi && phase_i.phase_last));

endmodule

// File: sim.f
+incdir+common
+incdir+sim
common/vic_pkg.sv
timing/phase_gen.sv
raster/raster_counter.sv
raster/bus_arbiter.sv
regs/vic_registers.sv
src/vic_top.sv
sim/tb_vic.sv

// File: sim/tb_vic_tasks.svh
`ifndef TB_VIC_TASKS_SVH
`define TB_VIC_TASKS_SVH

// print the reason, then stop the run
task automatic report_error(input string msg);
   $display("%s", msg);
   $display("sim failed");
   $fatal(1, "run stopped at the first error");
endtask

task automatic expect_equal(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
   assert (got == exp) else begin
      $display("ERR %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
      report_error("value mismatch");
   end
endtask

// galois lfsr, taps 0xb8, one step per bit handed out
function automatic logic [7:0] lfsr_bits(input int n);
   logic [7:0] r;
   r = 8'h00;
   for (int i = 0; i < n; i++) begin
      r      = {r[6:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 8'hb8) : (lfsr_q >> 1);
   end
   return r;
endfunction

// returns at the negedge of the first tick after reset
task automatic apply_reset(input chip_t chip);
   @(posedge clk_dot4x);
   rst    <= 1'b1;
   chip_i <= chip;
   bus_i  <= BUS_IDLE;
   repeat (8) @(posedge clk_dot4x);
   rst <= 1'b0;
   @(negedge clk_dot4x);
endtask

task automatic wait_line(input logic [8:0] line, input int max_ticks);
   int n;
   n = 0;
   while (raster_o.raster_line != line) begin
      @(negedge clk_dot4x);
      n++;
      if (n > max_ticks) begin
         report_error($sformatf("timeout waiting for raster line %0d", line));
      end
   end
endtask

// one bus cycle in a phi high half, read data taken at its 16th tick
task automatic cpu_access(input logic rw, input logic [5:0] adr, input logic [7:0] wdata,
                          output logic [7:0] rdata, output logic [8:0] line);
   while (phi_o) @(negedge clk_dot4x);
   while (!phi_o) @(negedge clk_dot4x);
   @(posedge clk_dot4x);
   bus_i <= '{ce_n: 1'b0, rw: rw, adr: adr, wdata: wdata};
   repeat (15) @(negedge clk_dot4x);
   expect_equal("phi_o at bus sample", 32'(phi_o), 32'd1);
   rdata = dbo_o;
   line  = raster_o.raster_line;
   // the register file takes the write on this edge
   @(posedge clk_dot4x);
   bus_i <= BUS_IDLE;
   @(negedge clk_dot4x);
endtask

task automatic cpu_write(input logic [5:0] adr, input logic [7:0] wdata);
   logic [7:0] rd;
   logic [8:0] line;
   cpu_access(1'b0, adr, wdata, rd, line);
endtask

task automatic cpu_read(input logic [5:0] adr, output logic [7:0] rdata,
                        output logic [8:0] line);
   cpu_access(1'b1, adr, 8'h00, rdata, line);
endtask

// 16 ticks per half, one ras and one later cas fall in each half
task automatic clock_and_strobes();
   logic level;
   logic prev_ras;
   logic prev_cas;
   int   ras_at;
   int   cas_at;
   int   ras_falls;
   int   cas_falls;
   expect_equal("ras_o after reset", 32'(ras_o), 32'd1);
   expect_equal("cas_o after reset", 32'(cas_o), 32'd1);
   expect_equal("ba_o after reset", 32'(ba_o), 32'd1);
   expect_equal("aec_o after reset", 32'(aec_o), 32'd0);
   level = phi_o;
   while (phi_o == level) @(negedge clk_dot4x);
   // park on the last tick of that half
   repeat (15) @(negedge clk_dot4x);
   level    = phi_o;
   prev_ras = ras_o;
   prev_cas = cas_o;
   for (int h = 0; h < 8; h++) begin
      ras_falls = 0;
      cas_falls = 0;
      ras_at    = 0;
      cas_at    = 0;
      for (int t = 1; t <= 16; t++) begin
         @(negedge clk_dot4x);
         expect_equal("phi_o", 32'(phi_o), 32'(!level));
         if (prev_ras && !ras_o) begin
            ras_falls++;
            ras_at = t;
         end
         if (prev_cas && !cas_o) begin
            cas_falls++;
            cas_at = t;
         end
         prev_ras = ras_o;
         prev_cas = cas_o;
      end
      expect_equal("ras_o at half end", 32'(ras_o), 32'd1);
      expect_equal("cas_o at half end", 32'(cas_o), 32'd1);
      expect_equal("ras_o falls per half", ras_falls, 1);
      expect_equal("cas_o falls per half", cas_falls, 1);
      assert (cas_at > ras_at) else begin
         report_error("cas_o did not fall after ras_o in a half-phase");
      end
      level = !level;
   end
endtask

// one whole frame: x steps by one up to its limit, line steps at each wrap
task automatic chip_limits(input chip_t chip, input logic [9:0] x_last,
                           input logic [8:0] y_last);
   raster_t prev;
   int      n;
   logic    done;
   apply_reset(chip);
   prev = raster_o;
   n    = 0;
   done = 1'b0;
   while (!done) begin
      @(negedge clk_dot4x);
      n++;
      if (n > FRAME_TICKS + LINE_TICKS) begin
         report_error("timeout waiting for the raster frame to wrap");
      end
      if (raster_o.raster_x == prev.raster_x) begin
         expect_equal("raster_line", 32'(raster_o.raster_line), 32'(prev.raster_line));
      end else if (raster_o.raster_x != 10'd0) begin
         expect_equal("raster_x", 32'(raster_o.raster_x), 32'(prev.raster_x + 10'd1));
      end else begin
         expect_equal("raster_x before wrap", 32'(prev.raster_x), 32'(x_last));
         if (raster_o.raster_line == 9'd0) begin
            expect_equal("raster_line before wrap", 32'(prev.raster_line), 32'(y_last));
            done = 1'b1;
         end else begin
            expect_equal("raster_line", 32'(raster_o.raster_line),
                         32'(prev.raster_line + 9'd1));
         end
      end
      prev = raster_o;
   end
endtask

task automatic register_access();
   logic [7:0] r;
   logic [7:0] rd;
   logic [8:0] line;
   apply_reset(CHIP_6569);
   // random den and yscroll, compare bit 8 set
   r = lfsr_bits(4);
   cpu_write(`REG_CTRL1, {1'b1, 2'b00, r[3], 1'b0, r[2:0]});
   cpu_read(`REG_CTRL1, rd, line);
   expect_equal("dbo_o ctrl1", 32'(rd), 32'({line[8], 2'b00, r[3], 1'b0, r[2:0]}));
   cpu_write(`REG_RASTER, lfsr_bits(8));
   // raster reads return the live line
   cpu_read(`REG_RASTER, rd, line);
   expect_equal("dbo_o raster", 32'(rd), 32'(line[7:0]));
   cpu_read(`REG_IRQ_ENABLE, rd, line);
   expect_equal("dbo_o irq enable", 32'(rd), 32'h00);
   cpu_write(`REG_IRQ_ENABLE, 8'h01);
   cpu_read(`REG_IRQ_ENABLE, rd, line);
   expect_equal("dbo_o irq enable", 32'(rd), 32'h01);
   cpu_read(6'h00, rd, line);
   expect_equal("dbo_o unused 0x00", 32'(rd), 32'(`REG_RESERVED_VALUE));
   cpu_read(6'h3f, rd, line);
   expect_equal("dbo_o unused 0x3f", 32'(rd), 32'(`REG_RESERVED_VALUE));
endtask

task automatic raster_interrupt();
   logic [7:0] r;
   logic [7:0] rd;
   logic [8:0] line;
   logic [8:0] cmp;
   int         n;
   apply_reset(CHIP_6569);
   // a line in the first 64, ahead of the setup writes on line 0
   r   = lfsr_bits(6);
   cmp = {1'b0, r};
   if (cmp < 9'd2) begin
      cmp = cmp + 9'd2;
   end
   cpu_write(`REG_RASTER, cmp[7:0]);
   cpu_write(`REG_CTRL1, 8'h00);
   // the reset compare value already hit line 0
   cpu_write(`REG_IRQ_STATUS, 8'h01);
   cpu_write(`REG_IRQ_ENABLE, 8'h01);
   expect_equal("irq_o before compare line", 32'(irq_o), 32'd0);
   n = 0;
   while (!irq_o) begin
      @(negedge clk_dot4x);
      n++;
      if (n > 66 * LINE_TICKS) begin
         report_error("timeout waiting for irq_o");
      end
   end
   expect_equal("raster_line at irq", 32'(raster_o.raster_line), 32'(cmp));
   cpu_read(`REG_IRQ_STATUS, rd, line);
   expect_equal("dbo_o irq status", 32'(rd), 32'h81);
   cpu_write(`REG_IRQ_STATUS, 8'h01);
   // no second hit on the same line
   while (raster_o.raster_line == cmp) begin
      expect_equal("irq_o after clear", 32'(irq_o), 32'd0);
      @(negedge clk_dot4x);
   end
endtask

task automatic badline_arbitration();
   int   n_high;
   logic seen_low;
   logic fell;
   logic rose;
   logic prev_phi;
   logic exp_ba;
   apply_reset(CHIP_6569);
   // den on, yscroll 3, line 51 becomes a badline
   cpu_write(`REG_CTRL1, 8'h13);
   wait_line(9'd51, 52 * LINE_TICKS);
   n_high   = 0;
   seen_low = 1'b0;
   fell     = 1'b0;
   rose     = 1'b0;
   prev_phi = phi_o;
   while (raster_o.raster_line == 9'd51) begin
      exp_ba = !(raster_o.raster_x[9:3] >= `BA_CHARS_FIRST &&
                 raster_o.raster_x[9:3] <= `BA_CHARS_LAST);
      expect_equal("ba_o", 32'(ba_o), 32'(exp_ba));
      if (!ba_o) begin
         fell = 1'b1;
      end else if (fell) begin
         rose = 1'b1;
      end
      // count finished phi high halves that saw ba low
      if (prev_phi && !phi_o && seen_low) begin
         n_high++;
         seen_low = 1'b0;
      end
      if (phi_o && !ba_o) begin
         seen_low = 1'b1;
      end
      if (!fell) begin
         expect_equal("aec_o", 32'(aec_o), 32'(phi_o));
      end else if (!rose) begin
         expect_equal("aec_o", 32'(aec_o), 32'((n_high < 3) ? phi_o : 1'b0));
      end
      prev_phi = phi_o;
      @(negedge clk_dot4x);
   end
   expect_equal("ba_o fell on line 51", 32'(fell), 32'd1);
   while (raster_o.raster_line == 9'd52) begin
      expect_equal("aec_o on line 52", 32'(aec_o), 32'(phi_o));
      @(negedge clk_dot4x);
   end
endtask

// den stays 0 from reset, so no line steals the bus
task automatic den_off_no_badline();
   int n;
   apply_reset(CHIP_6569);
   n = 0;
   while (raster_o.raster_line <= 9'd60) begin
      expect_equal("ba_o with den off", 32'(ba_o), 32'd1);
      @(negedge clk_dot4x);
      n++;
      if (n > 62 * LINE_TICKS) begin
         report_error("timeout waiting for raster line 61");
      end
   end
endtask

`endif

// File: sim/tb_vic.sv
`timescale 1ns/1ps
`include "vic_consts.svh"

module tb_vic
   import vic_pkg::*;
();

   // pal line and frame in clk_dot4x ticks
   localparam int LINE_TICKS  = 504 * 4;
   localparam int FRAME_TICKS = 312 * LINE_TICKS;
   // three chip frames plus the irq and badline runs fit in five pal frames
   localparam int WATCHDOG_NS = 5 * FRAME_TICKS * 4;

   localparam cpu_bus_t BUS_IDLE = '{ce_n: 1'b1, rw: 1'b1, adr: 6'h00, wdata: 8'h00};

   logic       clk_dot4x;
   logic       rst;
   chip_t      chip_i;
   cpu_bus_t   bus_i;
   logic [7:0] dbo_o;
   logic       irq_o;
   logic       ba_o;
   logic       aec_o;
   logic       phi_o;
   logic       ras_o;
   logic       cas_o;
   raster_t    raster_o;
   // lfsr state for the random picks
   logic [7:0] lfsr_q;

   vic_top u_dut (
      .clk_dot4x (clk_dot4x),
      .rst       (rst),
      .chip_i    (chip_i),
      .bus_i     (bus_i),
      .dbo_o     (dbo_o),
      .irq_o     (irq_o),
      .ba_o      (ba_o),
      .aec_o     (aec_o),
      .phi_o     (phi_o),
      .ras_o     (ras_o),
      .cas_o     (cas_o),
      .raster_o  (raster_o)
   );

   `include "tb_vic_tasks.svh"

   // 4 ns dot4x clock
   always #2 clk_dot4x = ~clk_dot4x;

   // cpu may only own the bus while phi is high, in every test
   always @(negedge clk_dot4x) begin
      if (!rst) begin
         assert (!(aec_o && !phi_o)) else begin
            report_error("aec_o was high while phi_o was low");
         end
      end
   end

   initial begin
      #(WATCHDOG_NS);
      report_error("watchdog timeout, the tests did not finish in time");
   end

   initial begin
      lfsr_q    = 8'd84;
      clk_dot4x = 1'b0;
      rst       = 1'b1;
      chip_i    = CHIP_6569;
      bus_i     = BUS_IDLE;
      apply_reset(CHIP_6569);
      clock_and_strobes();
      chip_limits(CHIP_R8, `RASTER_X_MAX_R8, `RASTER_Y_MAX_R8);
      chip_limits(CHIP_R56A, `RASTER_X_MAX_R56A, `RASTER_Y_MAX_R56A);
      chip_limits(CHIP_6569, `RASTER_X_MAX_6569, `RASTER_Y_MAX_6569);
      register_access();
      raster_interrupt();
      badline_arbitration();
      den_off_no_badline();
      $display("sim passed");
      $finish;
   end

endmodule

// File: src/vic_top.sv
`timescale 1ns/1ps

module vic_top
   import vic_pkg::*;
(
   input  logic       clk_dot4x,
   input  logic       rst,
   input  chip_t      chip_i,
   input  cpu_bus_t   bus_i,
   output logic [7:0] dbo_o,
   output logic       irq_o,
   output logic       ba_o,
   output logic       aec_o,
   output logic       phi_o,
   output logic       ras_o,
   output logic       cas_o,
   output raster_t    raster_o
);

   phase_t  phase;
   raster_t raster;
   ctrl_t   ctrl;

   // phi, dot strobe and dram strobes
   phase_gen u_phase_gen (
      .clk_dot4x (clk_dot4x),
      .rst       (rst),
      .phase_o   (phase),
      .ras_o     (ras_o),
      .cas_o     (cas_o)
   );

   // beam position
   raster_counter u_raster_counter (
      .clk_dot4x (clk_dot4x),
      .rst       (rst),
      .chip_i    (chip_i),
      .phase_i   (phase),
      .raster_o  (raster)
   );

   // cpu registers and raster irq
   vic_registers u_vic_registers (
      .clk_dot4x (clk_dot4x),
      .rst       (rst),
      .phase_i   (phase),
      .raster_i  (raster),
      .bus_i     (bus_i),
      .ctrl_o    (ctrl),
      .dbo_o     (dbo_o),
      .irq_o     (irq_o)
   );

   // badlines steal the bus through ba/aec
   bus_arbiter u_bus_arbiter (
      .clk_dot4x (clk_dot4x),
      .rst       (rst),
      .phase_i   (phase),
      .raster_i  (raster),
      .ctrl_i    (ctrl),
      .ba_o      (ba_o),
      .aec_o     (aec_o)
   );

   assign phi_o    = phase.phi;
   assign raster_o = raster;

endmodule

// File: timing/phase_gen.sv
`timescale 1ns/1ps
`include "vic_consts.svh"

module phase_gen
   import vic_pkg::*;
(
   input  logic   clk_dot4x,
   input  logic   rst,
   output phase_t phase_o,
   output logic   ras_o,
   output logic   cas_o
);

   localparam int HALF = `TICKS_PER_HALF;

   // phi pattern, msb is the current phi level
   logic [2*HALF-1:0] phi_q;
   // one-hot position inside the half-phase, bit 0 is the first tick
   logic [HALF-1:0]   pos_q;
   // one-hot dot position, bit 3 is the tick before a dot edge
   logic [3:0]        dot_q;
   logic [15:0]       ras_q;
   logic [15:0]       cas_q;

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         // leave reset at the first tick of a phi low half
         phi_q <= {{HALF{1'b0}}, {HALF{1'b1}}};
         pos_q <= {{(HALF-1){1'b0}}, 1'b1};
         dot_q <= 4'b0001;
      end else begin
         phi_q <= {phi_q[2*HALF-2:0], phi_q[2*HALF-1]};
         pos_q <= {pos_q[HALF-2:0], pos_q[HALF-1]};
         dot_q <= {dot_q[2:0], dot_q[3]};
      end
   end

   // profiles reload on the third tick and drain with ones,
   // so both strobes idle high until the next reload
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         ras_q <= 16'hffff;
         cas_q <= 16'hffff;
      end else if (pos_q[2]) begin
         ras_q <= `RAS_PROFILE;
         cas_q <= `CAS_PROFILE;
      end else begin
         ras_q <= {ras_q[14:0], 1'b1};
         cas_q <= {cas_q[14:0], 1'b1};
      end
   end

   assign phase_o = '{phi:         phi_q[2*HALF-1],
                      dot_rise:    dot_q[3],
                      phase_first: pos_q[0],
                      phase_last:  pos_q[HALF-1],
                      phase_third: pos_q[2]};
   assign ras_o = ras_q[15];
   assign cas_o = cas_q[15];

   a_first_last_apart: assert property (@(posedge clk_dot4x) disable iff (rst)
      !(phase_o.phase_first && phase_o.phase_last));

   // dram needs the row latched before the column
   a_cas_after_ras: assert property (@(posedge clk_dot4x) disable iff (rst)
      $fell(cas_o) |-> !ras_o);

endmodule
